// File: design/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu
  import ex_pkg::*;
(
  input  wire alu_op_e op_i,
  input  wire xdata_t  src1_i,
  input  wire xdata_t  src2_i,
  output xdata_t       result_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = src2_i[4:0]; // RV32I shifts ignore the upper bits.
  assign lt_signed   = $signed(src1_i) < $signed(src2_i);
  assign lt_unsigned = src1_i < src2_i;

  // ******************************
  // Operation select
  // ******************************

  always_comb begin
    case (op_i)
      ALU_ADD: begin
        result_o = src1_i + src2_i;
      end
      ALU_SUB: begin
        result_o = src1_i - src2_i;
      end
      ALU_SLL: begin
        result_o = src1_i << shamt;
      end
      ALU_SLT: begin
        result_o = {{(XLEN-1){1'b0}}, lt_signed};
      end
      ALU_SLTU: begin
        result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      end
      ALU_XOR: begin
        result_o = src1_i ^ src2_i;
      end
      ALU_SRL: begin
        result_o = src1_i >> shamt;
      end
      ALU_SRA: begin
        result_o = xdata_t'($signed(src1_i) >>> shamt);
      end
      ALU_OR: begin
        result_o = src1_i | src2_i;
      end
      ALU_AND: begin
        result_o = src1_i & src2_i;
      end
      ALU_PASSB: begin
        result_o = src2_i; // lui places the immediate directly.
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/ex_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit
  import ex_pkg::*;
(
  input  wire id_ex_t id_ex_i,
  input  wire xdata_t rs1_i,
  input  wire xdata_t rs2_i,
  output redirect_t   redirect_o
);

  // ******************************
  // Target and decision
  // ******************************

  always_comb begin
    redirect_o.target = id_ex_i.pc + id_ex_i.imm;
    redirect_o.taken  = id_ex_i.is_jal | id_ex_i.is_jalr;
    if (id_ex_i.is_jalr) begin
      redirect_o.target = (rs1_i + id_ex_i.imm) & ~xdata_t'(1);
    end
    if (id_ex_i.is_brc) begin
      case (id_ex_i.instr[14:12])
        3'd0:    redirect_o.taken = (rs1_i == rs2_i);
        3'd1:    redirect_o.taken = (rs1_i != rs2_i);
        3'd4:    redirect_o.taken = ($signed(rs1_i) <  $signed(rs2_i));
        3'd5:    redirect_o.taken = ($signed(rs1_i) >= $signed(rs2_i));
        3'd6:    redirect_o.taken = (rs1_i <  rs2_i);
        3'd7:    redirect_o.taken = (rs1_i >= rs2_i);
        default: redirect_o.taken = 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/ex_mem_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg
  import ex_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n_i,
  input  wire         stall_n_i,
  input  wire id_ex_t id_ex_i,
  input  wire xdata_t rs2_i,
  input  wire xdata_t result_i,
  output ex_mem_t     ex_mem_o
);

  ex_mem_t ex_mem_d;

  // ******************************
  // Bundle assembly
  // ******************************

  always_comb begin
    ex_mem_d.pc         = id_ex_i.pc;
    ex_mem_d.instr      = id_ex_i.instr;
    ex_mem_d.result     = result_i;
    ex_mem_d.store_data = rs2_i;                // Forwarded value, for stores.
    ex_mem_d.rd_idx     = id_ex_i.instr[11:7];
    ex_mem_d.trap       = id_ex_i.trap;
    // A write to x0 is dropped here so it can never forward or retire.
    ex_mem_d.wben       = id_ex_i.wben && (id_ex_i.instr[11:7] != '0);
  end

  // ******************************
  // Pipeline register
  // ******************************

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_mem_o <= '0;
    end else if (stall_n_i) begin
      ex_mem_o <= ex_mem_d;
    end
  end

endmodule

`default_nettype wire

// File: design/ex_operand_sel.sv
`timescale 1ns/1ps
`default_nettype none

module ex_operand_sel
  import ex_pkg::*;
(
  input  wire id_ex_t  id_ex_i,
  input  wire ex_mem_t fwd_i,
  output xdata_t       rs1_o,
  output xdata_t       rs2_o,
  output xdata_t       src1_o,
  output xdata_t       src2_o
);

  logic fwd_valid;
  logic fwd_rs1;
  logic fwd_rs2;

  // ******************************
  // Forwarding from EX/MEM
  // ******************************

  // Writes to x0 never forward, even if wben were set.
  assign fwd_valid = fwd_i.wben && (fwd_i.rd_idx != '0);
  assign fwd_rs1   = fwd_valid && (fwd_i.rd_idx == id_ex_i.rs1_idx);
  assign fwd_rs2   = fwd_valid && (fwd_i.rd_idx == id_ex_i.rs2_idx);

  assign rs1_o = fwd_rs1 ? fwd_i.result : id_ex_i.rs1;
  assign rs2_o = fwd_rs2 ? fwd_i.result : id_ex_i.rs2;

  // ******************************
  // Source multiplexers
  // ******************************

  assign src1_o = id_ex_i.src1sel ? id_ex_i.pc : rs1_o; // pc for auipc and links.

  always_comb begin
    case (id_ex_i.src2sel)
      SRC2_RS2:  src2_o = rs2_o;
      SRC2_IMM:  src2_o = id_ex_i.imm;
      SRC2_FOUR: src2_o = LINK_OFFSET;
      default:   src2_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/ex_pkg.sv
`default_nettype none

package ex_pkg;

  // ******************************
  // Widths and constants
  // ******************************

  localparam int XLEN     = 32;
  localparam int INST_LEN = 32;
  localparam int REG_IDX_W = 5;

  typedef logic [XLEN-1:0]      xdata_t;
  typedef logic [INST_LEN-1:0]  inst_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  localparam inst_t  NOP_INSTR   = 32'h0000_0013; // addi x0, x0, 0
  localparam xdata_t LINK_OFFSET = 32'd4;         // Return address step for jal and jalr.

  // ******************************
  // Control encodings
  // ******************************

  typedef enum logic [4:0] {
    ALU_ADD   = 5'd0,
    ALU_SUB   = 5'd1,
    ALU_SLL   = 5'd2,
    ALU_SLT   = 5'd3,
    ALU_SLTU  = 5'd4,
    ALU_XOR   = 5'd5,
    ALU_SRL   = 5'd6,
    ALU_SRA   = 5'd7,
    ALU_OR    = 5'd8,
    ALU_AND   = 5'd9,
    ALU_PASSB = 5'd10  // Used by lui.
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC2_RS2  = 2'd0,
    SRC2_IMM  = 2'd1,
    SRC2_FOUR = 2'd2
  } src2_sel_e;

  // ******************************
  // Stage bundles
  // ******************************

  typedef struct packed {
    xdata_t    pc;
    inst_t     instr;
    xdata_t    rs1;
    xdata_t    rs2;
    xdata_t    imm;
    alu_op_e   aluctr;
    logic      is_jalr;
    logic      is_jal;
    logic      is_brc;
    logic      src1sel;   // 0 selects rs1, 1 selects pc.
    src2_sel_e src2sel;
    logic      wben;
    reg_idx_t  rs1_idx;
    reg_idx_t  rs2_idx;
    logic      trap;
  } id_ex_t;

  typedef struct packed {
    xdata_t   pc;
    inst_t    instr;
    xdata_t   result;
    xdata_t   store_data;
    reg_idx_t rd_idx;
    logic     wben;
    logic     trap;
  } ex_mem_t;

  typedef struct packed {
    logic   taken;
    xdata_t target;
  } redirect_t;

endpackage

`default_nettype wire

// File: design/ex_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_top
  import ex_pkg::*;
(
  input  wire          clk,
  input  wire          rst_n_i,
  input  wire id_ex_t  id_ex_i,
  input  wire          stall_n_i,
  input  wire          flush_i,
  output ex_mem_t      ex_mem_o,
  output redirect_t    redirect_o
);

  id_ex_t    id_ex_q;
  ex_mem_t   ex_mem_q;
  redirect_t redirect;
  xdata_t    rs1_fwd;
  xdata_t    rs2_fwd;
  xdata_t    src1;
  xdata_t    src2;
  xdata_t    alu_result;
  logic      id_ex_flush;

  // A taken redirect kills the instruction entering behind it.
  assign id_ex_flush = flush_i | redirect.taken;

  // ******************************
  // Input side
  // ******************************

  id_ex_reg i_id_ex_reg (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .stall_n_i (stall_n_i),
    .flush_i   (id_ex_flush),
    .id_ex_i   (id_ex_i),
    .id_ex_o   (id_ex_q)
  );

  // ******************************
  // Processing
  // ******************************

  ex_operand_sel i_ex_operand_sel (
    .id_ex_i (id_ex_q),
    .fwd_i   (ex_mem_q),
    .rs1_o   (rs1_fwd),
    .rs2_o   (rs2_fwd),
    .src1_o  (src1),
    .src2_o  (src2)
  );

  ex_alu i_ex_alu (
    .op_i     (id_ex_q.aluctr),
    .src1_i   (src1),
    .src2_i   (src2),
    .result_o (alu_result)
  );

  ex_branch_unit i_ex_branch_unit (
    .id_ex_i    (id_ex_q),
    .rs1_i      (rs1_fwd),
    .rs2_i      (rs2_fwd),
    .redirect_o (redirect)
  );

  // ******************************
  // Output side
  // ******************************

  ex_mem_reg i_ex_mem_reg (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .stall_n_i (stall_n_i),
    .id_ex_i   (id_ex_q),
    .rs2_i     (rs2_fwd),
    .result_i  (alu_result),
    .ex_mem_o  (ex_mem_q)
  );

  assign ex_mem_o   = ex_mem_q;
  assign redirect_o = redirect;

endmodule

`default_nettype wire

// File: design/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg
  import ex_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n_i,
  input  wire         stall_n_i,
  input  wire         flush_i,
  input  wire id_ex_t id_ex_i,
  output id_ex_t      id_ex_o
);

  id_ex_t id_ex_d;

  // ******************************
  // Flush kill
  // ******************************

  // Only the fields that can cause an architectural effect are cleared.
  // Operands, indices and ALU control pass through untouched.
  always_comb begin
    id_ex_d = id_ex_i;
    if (flush_i) begin
      id_ex_d.pc      = '0;
      id_ex_d.instr   = NOP_INSTR;
      id_ex_d.is_jalr = 1'b0;
      id_ex_d.is_jal  = 1'b0;
      id_ex_d.is_brc  = 1'b0;
      id_ex_d.wben    = 1'b0;
      id_ex_d.trap    = 1'b0;
    end
  end

  // ******************************
  // Pipeline register
  // ******************************

  // A low stall_n_i holds everything, including a pending flush.
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex_o <= '0;
    end else if (stall_n_i) begin
      id_ex_o <= id_ex_d;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the EX stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f verilog.f \
  --top-module ex_stage_tb \
  -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Compile step failed."
  exit 1
fi

./obj_dir/Vex_stage_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status."
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi

exit 0

// File: tb/ex_stage_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_checker
  import ex_pkg::*;
(
  input wire            clk,
  input wire            rst_n_i,
  input wire            stall_n_i,
  input wire            flush_i,
  input wire id_ex_t    id_ex_q_i,
  input wire ex_mem_t   ex_mem_o_i,
  input wire redirect_t redirect_o_i
);

  // ******************************
  // Pipeline control
  // ******************************

  a_flush_kills: assert property (@(posedge clk) disable iff (!rst_n_i)
    stall_n_i && flush_i |=> !id_ex_q_i.wben && !id_ex_q_i.trap)
    else $error("Flushed bundle kept wben or trap.");

  a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n_i)
    !stall_n_i |=> $stable(ex_mem_o_i))
    else $error("EX/MEM changed during a stall.");

  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(ex_mem_o_i.wben && ex_mem_o_i.rd_idx == 5'd0))
    else $error("Write enable set for x0.");

  // Right after reset both registers are empty.
  a_reset_quiet: assert property (@(posedge clk)
    $rose(rst_n_i) |-> !redirect_o_i.taken && !ex_mem_o_i.wben)
    else $error("Outputs active right after reset.");

endmodule

bind ex_stage_top ex_stage_checker i_ex_stage_checker (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .stall_n_i    (stall_n_i),
  .flush_i      (flush_i),
  .id_ex_q_i    (id_ex_q),
  .ex_mem_o_i   (ex_mem_o),
  .redirect_o_i (redirect_o)
);

`default_nettype wire

// File: tb/ex_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb
  import ex_pkg::*;
();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam int TEST_CYCLES  = 160; // Sum of the stimulus cycles of all tests, with margin.

  logic      clk;
  logic      rst_n_i;
  id_ex_t    id_ex_i;
  logic      stall_n_i;
  logic      flush_i;
  ex_mem_t   ex_mem_o;
  redirect_t redirect_o;

  id_ex_t    m_id_ex;   // Model copy of the ID/EX register.
  ex_mem_t   m_ex_mem;  // Model copy of the EX/MEM register.
  logic [31:0] lcg_state;
  int        errors;
  int        checks;
  int        tests_run;
  int        tests_failed;

  ex_stage_top i_ex_stage_top (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .id_ex_i    (id_ex_i),
    .stall_n_i  (stall_n_i),
    .flush_i    (flush_i),
    .ex_mem_o   (ex_mem_o),
    .redirect_o (redirect_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ******************************
  // Reference model
  // ******************************

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic xdata_t forward_value(reg_idx_t idx, xdata_t regval, ex_mem_t fwd);
    if (fwd.wben && fwd.rd_idx != 5'd0 && fwd.rd_idx == idx) return fwd.result;
    return regval;
  endfunction

  function automatic xdata_t alu_model(alu_op_e op, xdata_t a, xdata_t b);
    case (op)
      ALU_ADD:   return a + b;
      ALU_SUB:   return a - b;
      ALU_SLL:   return a << b[4:0];
      ALU_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU:  return (a < b) ? 32'd1 : 32'd0;
      ALU_XOR:   return a ^ b;
      ALU_SRL:   return a >> b[4:0];
      ALU_SRA:   return xdata_t'($signed(a) >>> b[4:0]);
      ALU_OR:    return a | b;
      ALU_AND:   return a & b;
      ALU_PASSB: return b;
      default:   return '0;
    endcase
  endfunction

  function automatic redirect_t redirect_model(id_ex_t s, ex_mem_t fwd);
    redirect_t r;
    xdata_t    a;
    xdata_t    b;
    a = forward_value(s.rs1_idx, s.rs1, fwd);
    b = forward_value(s.rs2_idx, s.rs2, fwd);
    r.target = s.pc + s.imm;
    r.taken  = s.is_jal | s.is_jalr;
    if (s.is_jalr) r.target = (a + s.imm) & ~32'd1;
    if (s.is_brc) begin
      case (s.instr[14:12])
        3'd0: r.taken = (a == b);
        3'd1: r.taken = (a != b);
        3'd4: r.taken = ($signed(a) < $signed(b));
        3'd5: r.taken = ($signed(a) >= $signed(b));
        3'd6: r.taken = (a < b);
        3'd7: r.taken = (a >= b);
        default: r.taken = 1'b0;
      endcase
    end
    return r;
  endfunction

  always @(posedge clk or negedge rst_n_i) begin
    redirect_t r;
    id_ex_t    nxt;
    ex_mem_t   em;
    xdata_t    a;
    xdata_t    b;
    if (!rst_n_i) begin
      m_id_ex  <= '0;
      m_ex_mem <= '0;
    end else if (stall_n_i) begin
      r   = redirect_model(m_id_ex, m_ex_mem);
      nxt = id_ex_i;
      if (flush_i || r.taken) begin
        nxt.pc = '0;
        nxt.instr = NOP_INSTR;
        nxt.is_jalr = 1'b0;
        nxt.is_jal = 1'b0;
        nxt.is_brc = 1'b0;
        nxt.wben = 1'b0;
        nxt.trap = 1'b0;
      end
      a = m_id_ex.src1sel ? m_id_ex.pc : forward_value(m_id_ex.rs1_idx, m_id_ex.rs1, m_ex_mem);
      b = forward_value(m_id_ex.rs2_idx, m_id_ex.rs2, m_ex_mem);
      em.pc         = m_id_ex.pc;
      em.instr      = m_id_ex.instr;
      em.store_data = b;
      em.rd_idx     = m_id_ex.instr[11:7];
      em.trap       = m_id_ex.trap;
      em.wben       = m_id_ex.wben && (m_id_ex.instr[11:7] != 5'd0);
      case (m_id_ex.src2sel)
        SRC2_RS2:  em.result = alu_model(m_id_ex.aluctr, a, b);
        SRC2_IMM:  em.result = alu_model(m_id_ex.aluctr, a, m_id_ex.imm);
        SRC2_FOUR: em.result = alu_model(m_id_ex.aluctr, a, 32'd4);
        default:   em.result = alu_model(m_id_ex.aluctr, a, 32'd0);
      endcase
      m_id_ex  <= nxt;
      m_ex_mem <= em;
    end
  end

  // Outputs are compared in the middle of the cycle, where they are settled.
  always @(negedge clk) begin
    redirect_t r;
    if (rst_n_i) begin
      r = redirect_model(m_id_ex, m_ex_mem);
      checks++;
      a_ex_mem: assert (ex_mem_o === m_ex_mem) else begin
        errors++;
        $display("Fail ex_mem_o expected %h got %h", m_ex_mem, ex_mem_o);
      end
      a_taken: assert (redirect_o.taken === r.taken) else begin
        errors++;
        $display("Fail redirect_o.taken expected %h got %h", r.taken, redirect_o.taken);
      end
      a_target: assert (!r.taken || redirect_o.target === r.target) else begin
        errors++;
        $display("Fail redirect_o.target expected %h got %h", r.target, redirect_o.target);
      end
    end
  end

  // ******************************
  // Stimulus helpers
  // ******************************

  function automatic id_ex_t make_op(alu_op_e op, reg_idx_t rd, reg_idx_t s1, reg_idx_t s2,
                                     xdata_t v1, xdata_t v2, xdata_t imm, src2_sel_e sel);
    id_ex_t b;
    b = '0;
    b.pc      = 32'h0000_1000 + {rd, 2'b00};
    b.instr   = {7'd0, s2, s1, 3'd0, rd, 7'h33};
    b.rs1     = v1;
    b.rs2     = v2;
    b.imm     = imm;
    b.aluctr  = op;
    b.src2sel = sel;
    b.wben    = 1'b1;
    b.rs1_idx = s1;
    b.rs2_idx = s2;
    return b;
  endfunction

  function automatic id_ex_t make_branch(logic [2:0] f3, xdata_t v1, xdata_t v2);
    id_ex_t b;
    b = make_op(ALU_ADD, 5'd0, 5'd11, 5'd12, v1, v2, 32'h40, SRC2_RS2);
    b.instr[14:12] = f3;
    b.wben   = 1'b0;
    b.is_brc = 1'b1;
    return b;
  endfunction

  task automatic issue(input id_ex_t b, input logic fl);
    @(posedge clk);
    id_ex_i   <= b;
    stall_n_i <= 1'b1;
    flush_i   <= fl;
  endtask

  task automatic idle(input int n);
    repeat (n) issue('0, 1'b0);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - err_before);
    end
  endtask

  // ******************************
  // Tests
  // ******************************

  initial begin
    int       e0;
    ex_mem_t  held;
    id_ex_t   b;
    lcg_state = 32'h73c7dc86;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    rst_n_i   = 1'b0;
    id_ex_i   = '0;
    stall_n_i = 1'b1;
    flush_i   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n_i <= 1'b1;

    e0 = errors;
    @(negedge clk);
    a_reset: assert (ex_mem_o === '0 && redirect_o.taken === 1'b0) else begin
      errors++;
      $display("Fail ex_mem_o expected 0 got %h, redirect_o.taken expected 0 got %h",
               ex_mem_o, redirect_o.taken);
    end
    finish_test("reset", e0);

    e0 = errors;
    for (int i = 0; i < 24; i++) begin
      issue(make_op(alu_op_e'(next_random() % 11), reg_idx_t'(next_random()),
                    reg_idx_t'(next_random()), reg_idx_t'(next_random()), next_random(),
                    next_random(), next_random(), (next_random() & 1) ? SRC2_IMM : SRC2_RS2),
            1'b0);
    end
    idle(3);
    finish_test("alu_random", e0);

    e0 = errors;
    issue(make_op(ALU_ADD, 5'd5, 5'd1, 5'd2, 32'd10, 32'd20, 32'd0, SRC2_RS2), 1'b0);
    issue(make_op(ALU_SUB, 5'd6, 5'd5, 5'd5, 32'd0, 32'd0, 32'd0, SRC2_RS2), 1'b0);
    issue(make_op(ALU_ADD, 5'd0, 5'd1, 5'd2, 32'd7, 32'd8, 32'd0, SRC2_RS2), 1'b0);
    issue(make_op(ALU_ADD, 5'd7, 5'd0, 5'd0, 32'd3, 32'd4, 32'd0, SRC2_RS2), 1'b0);
    b = make_op(ALU_ADD, 5'd8, 5'd0, 5'd0, 32'd0, 32'd0, 32'h0000_5000, SRC2_IMM);
    b.src1sel = 1'b1;
    issue(b, 1'b0);
    b = make_op(ALU_ADD, 5'd9, 5'd0, 5'd0, 32'd0, 32'd0, 32'd0, SRC2_FOUR);
    b.src1sel = 1'b1;
    issue(b, 1'b0);
    idle(3);
    finish_test("forwarding", e0);

    // Three operand pairs so that every condition is seen both taken and not taken.
    e0 = errors;
    for (int f = 0; f < 8; f++) begin
      if (f == 2 || f == 3) continue;
      issue(make_branch(3'(f), 32'hffff_fff0, 32'h10), 1'b0);
      issue(make_op(ALU_ADD, 5'd3, 5'd1, 5'd2, 32'd1, 32'd1, 32'd0, SRC2_RS2), 1'b0);
      issue(make_branch(3'(f), 32'h22, 32'h22), 1'b0);
      issue(make_op(ALU_ADD, 5'd3, 5'd1, 5'd2, 32'd1, 32'd1, 32'd0, SRC2_RS2), 1'b0);
      issue(make_branch(3'(f), 32'h10, 32'hffff_fff0), 1'b0);
      issue(make_op(ALU_ADD, 5'd3, 5'd1, 5'd2, 32'd1, 32'd1, 32'd0, SRC2_RS2), 1'b0);
    end
    b = make_op(ALU_ADD, 5'd1, 5'd0, 5'd0, 32'd0, 32'd0, 32'h0000_0100, SRC2_FOUR);
    b.src1sel = 1'b1;
    b.is_jal  = 1'b1;
    issue(b, 1'b0);
    issue(make_op(ALU_ADD, 5'd3, 5'd1, 5'd2, 32'd1, 32'd1, 32'd0, SRC2_RS2), 1'b0);
    b.is_jal  = 1'b0;
    b.is_jalr = 1'b1;
    b.rs1     = 32'h0000_2003;
    b.rs1_idx = 5'd14;
    issue(b, 1'b0);
    issue(make_op(ALU_ADD, 5'd3, 5'd1, 5'd2, 32'd1, 32'd1, 32'd0, SRC2_RS2), 1'b0);
    idle(3);
    finish_test("branch_jump", e0);

    e0 = errors;
    issue(make_op(ALU_XOR, 5'd4, 5'd1, 5'd2, 32'h55aa, 32'h0ff0, 32'd0, SRC2_RS2), 1'b0);
    issue(make_op(ALU_OR, 5'd10, 5'd1, 5'd2, 32'h1200, 32'h0034, 32'd0, SRC2_RS2), 1'b0);
    @(posedge clk);
    stall_n_i <= 1'b0;
    @(negedge clk);
    held = ex_mem_o;
    repeat (5) begin
      @(negedge clk);
      a_hold: assert (ex_mem_o === held) else begin
        errors++;
        $display("Fail ex_mem_o expected %h got %h", held, ex_mem_o);
      end
    end
    idle(4);
    finish_test("stall", e0);

    // The killed branch sits in ID/EX one cycle, and reaches EX/MEM the cycle after.
    e0 = errors;
    b = make_branch(3'd0, 32'd1, 32'd1);
    b.wben = 1'b1;
    b.trap = 1'b1;
    b.instr[11:7] = 5'd13;
    issue(b, 1'b1);
    issue('0, 1'b0);
    @(negedge clk);
    a_flush_redirect: assert (redirect_o.taken === 1'b0) else begin
      errors++;
      $display("Fail redirect_o.taken expected 0 got %h", redirect_o.taken);
    end
    @(negedge clk);
    a_flush: assert (ex_mem_o.wben === 1'b0 && ex_mem_o.trap === 1'b0 &&
                     ex_mem_o.instr === NOP_INSTR) else begin
      errors++;
      $display("Fail ex_mem_o wben %h trap %h instr %h, expected 0 0 %h",
               ex_mem_o.wben, ex_mem_o.trap, ex_mem_o.instr, NOP_INSTR);
    end
    idle(2);
    finish_test("flush", e0);

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(RESET_CYCLES * CLK_PERIOD + TEST_CYCLES * CLK_PERIOD * 2);
    $display("Timeout: the tests did not finish in the expected time.");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
design/ex_pkg.sv
design/id_ex_reg.sv
design/ex_operand_sel.sv
design/ex_alu.sv
design/ex_branch_unit.sv
design/ex_mem_reg.sv
design/ex_stage_top.sv
tb/ex_stage_checker.sv
tb/ex_stage_tb.sv
